// File: bus_pkg.sv
// Processor operation and controller state encodings used by the cache controller and top
package bus_pkg;

    // Processor request kinds
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01,
        OP_FLUSH = 2'b10   // Invalidate the whole cache
    } cpu_op_t;

    // Cache controller FSM states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,  // Accepts snoop or processor request
        LOOKUP = 3'd1,  // Tag compare on the registered address
        REFILL = 3'd2,  // Waiting on the coherence unit
        SNOOP  = 3'd3,  // Snoop lookup and state update
        FLUSH  = 3'd4   // Walks every index
    } ctrl_state_t;

endpackage

// File: cache_config.svh
// Cache geometry and width macros, included by the packages and the RTL files
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`define ADDR_W          32   // Byte address
`define WORD_W          32   // Processor data word

// Address split into tag, index and byte offset
`define TAG_W           20
`define INDEX_W         8
`define OFFSET_W        4

`define LINES           256  // Direct mapped with one line per index
`define WORDS_PER_LINE  4
`define LINE_W          128  // WORDS_PER_LINE * WORD_W

`endif

// File: cache_ctrl.sv
// L1 cache controller FSM for processor requests, refills, snoops and flush
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl import cache_pkg::*, bus_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    store_if.ctrl               sif,

    // Processor request and response
    input  logic                cpu_valid,
    output logic                cpu_ready,
    input  cpu_op_t             cpu_op,
    input  logic [`ADDR_W-1:0]  cpu_addr,
    input  logic [`WORD_W-1:0]  cpu_wdata,
    output logic                resp_valid,
    output logic [`WORD_W-1:0]  resp_rdata,
    output logic                resp_hit,

    // Refill request and data
    output logic                fill_req_valid,
    input  logic                fill_req_ready,
    output logic [`ADDR_W-1:0]  fill_addr,
    input  logic                fill_valid,
    input  logic [`LINE_W-1:0]  fill_line,
    input  mesi_t               fill_state,

    // Snoop request and response
    input  logic                snoop_valid,
    output logic                snoop_ready,
    input  logic [`ADDR_W-1:0]  snoop_addr,
    input  mesi_t               snoop_new_state,
    output logic                snoop_resp_valid,
    output logic                snoop_hit,
    output logic [`WORD_W-1:0]  snoop_data,
    output mesi_t               snoop_state
);

    ctrl_state_t state_q;
    ctrl_state_t next_state;

    logic [`ADDR_W-1:0]  req_addr;     // Processor or snoop address
    cpu_op_t             op_q;
    logic [`WORD_W-1:0]  wdata_q;
    mesi_t               new_state_q;  // State named by the snoop
    logic                req_pending;  // Refill request not yet accepted
    logic [`INDEX_W-1:0] flush_cnt;

    logic [`TAG_W-1:0]   req_tag;
    logic [`INDEX_W-1:0] req_index;
    logic [1:0]          req_wsel;
    logic                cpu_acc;
    logic                snoop_acc;
    logic                lookup_hit;
    logic                refill_done;
    logic                flush_last;
    line_u               src_line;
    line_u               merged;

    assign req_tag   = req_addr[`ADDR_W-1 -: `TAG_W];
    assign req_index = req_addr[`OFFSET_W +: `INDEX_W];
    assign req_wsel  = req_addr[`OFFSET_W-1:2];  // Byte bits 1:0 ignored

    // Snoop wins over the processor in the same cycle
    assign snoop_ready = (state_q == IDLE);
    assign cpu_ready   = (state_q == IDLE) && !snoop_valid;
    assign snoop_acc   = snoop_valid && snoop_ready;
    assign cpu_acc     = cpu_valid && cpu_ready;

    assign lookup_hit  = (sif.rd_tag == req_tag) && (sif.rd_state != I);
    assign refill_done = (state_q == REFILL) && !req_pending && fill_valid;
    assign flush_last  = (state_q == FLUSH) && (flush_cnt == {`INDEX_W{1'b1}});

    always_comb begin
        next_state = state_q;
        case (state_q)
            IDLE: begin
                if (snoop_acc) begin
                    next_state = SNOOP;
                end else if (cpu_acc) begin
                    next_state = (cpu_op == OP_FLUSH) ? FLUSH : LOOKUP;
                end
            end
            LOOKUP:  next_state = lookup_hit ? IDLE : REFILL;
            REFILL:  next_state = refill_done ? IDLE : REFILL;
            SNOOP:   next_state = IDLE;
            FLUSH:   next_state = flush_last ? IDLE : FLUSH;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= IDLE;
            req_pending <= 1'b0;
            flush_cnt   <= '0;
        end else begin
            state_q <= next_state;
            if (state_q == LOOKUP && !lookup_hit) begin
                req_pending <= !fill_req_ready;  // Accepted already if ready
            end else if (state_q == REFILL && fill_req_ready) begin
                req_pending <= 1'b0;
            end
            if (cpu_acc && cpu_op == OP_FLUSH) begin
                flush_cnt <= '0;
            end else if (state_q == FLUSH) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (snoop_acc) begin
            req_addr    <= snoop_addr;
            new_state_q <= snoop_new_state;
        end else if (cpu_acc) begin
            req_addr <= cpu_addr;
            op_q     <= cpu_op;
            wdata_q  <= cpu_wdata;
        end
    end

    // Refill data or stored line with the written word merged in
    always_comb begin
        src_line = sif.rd_line;
        if (state_q == REFILL) begin
            src_line.block = fill_line;
        end
        merged = src_line;
        if (op_q == OP_WRITE) begin
            merged.words[req_wsel] = wdata_q;
        end
    end

    assign fill_req_valid = (state_q == LOOKUP && !lookup_hit) ||
                            (state_q == REFILL && req_pending);
    assign fill_addr      = {req_tag, req_index, {`OFFSET_W{1'b0}}};  // Line aligned

    assign resp_valid = (state_q == LOOKUP && lookup_hit) || refill_done || flush_last;
    assign resp_hit   = (state_q == LOOKUP) && lookup_hit;
    assign resp_rdata = merged.words[req_wsel];

    // Snoop reports the state before the update
    assign snoop_resp_valid = (state_q == SNOOP);
    assign snoop_hit        = (state_q == SNOOP) && lookup_hit;
    assign snoop_data       = sif.rd_line.words[req_wsel];
    assign snoop_state      = sif.rd_state;

    assign sif.rd_index = req_index;

    assign sif.line_we  = (state_q == LOOKUP && lookup_hit && op_q == OP_WRITE) ||
                          refill_done;
    assign sif.wr_index = req_index;
    assign sif.wr_tag   = req_tag;
    assign sif.wr_line  = merged;
    assign sif.wr_state = (op_q == OP_WRITE) ? M : fill_state;  // Written line becomes M

    assign sif.state_we = (state_q == SNOOP && lookup_hit) || (state_q == FLUSH);
    assign sif.st_index = (state_q == FLUSH) ? flush_cnt : req_index;
    assign sif.st_state = (state_q == FLUSH) ? I : new_state_q;

endmodule

// File: cache_pkg.sv
// Storage types of the L1 data cache, imported by the store interface, storage and controller
`include "cache_config.svh"

package cache_pkg;

    // MESI line state where I also marks an invalid line
    typedef enum logic [1:0] {
        M = 2'b00,   // Modified
        E = 2'b01,   // Exclusive
        S = 2'b10,   // Shared
        I = 2'b11    // Invalid
    } mesi_t;

    // One cache line seen as a whole block for refill and snoop
    // or as separate words for processor access
    typedef union packed {
        logic [`LINE_W-1:0]                      block;
        logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] words;  // Word 0 in low bits
    } line_u;

endpackage

// File: cache_store.sv
// Tag, line and MESI state arrays of the direct-mapped cache, driven by the controller
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_store import cache_pkg::*; (
    input logic    clk,
    input logic    rst,
    store_if.store sif
);

    logic [`TAG_W-1:0] tag_mem   [`LINES];
    line_u             line_mem  [`LINES];
    mesi_t             state_mem [`LINES];

    logic state_only;  // State write not overridden by a line write

    // Combinational lookup
    assign sif.rd_tag   = tag_mem[sif.rd_index];
    assign sif.rd_line  = line_mem[sif.rd_index];
    assign sif.rd_state = state_mem[sif.rd_index];

    assign state_only = sif.state_we &&
                        !(sif.line_we && (sif.wr_index == sif.st_index));

    // Tag and data of a full line write
    always_ff @(posedge clk) begin
        if (sif.line_we) begin
            tag_mem[sif.wr_index]  <= sif.wr_tag;
            line_mem[sif.wr_index] <= sif.wr_line;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `LINES; i++) begin
                state_mem[i] <= I;  // Every line starts invalid
            end
        end else begin
            if (state_only) begin
                state_mem[sif.st_index] <= sif.st_state;
            end
            if (sif.line_we) begin
                state_mem[sif.wr_index] <= sif.wr_state;
            end
        end
    end

endmodule

// File: l1_cache_top.sv
// Top level of the L1 data cache, connects the controller to the storage arrays
`timescale 1ns/1ps
`include "cache_config.svh"

module l1_cache_top import cache_pkg::*, bus_pkg::*; (
    input  logic                clk,
    input  logic                rst,

    // Processor side
    input  logic                cpu_valid,
    output logic                cpu_ready,
    input  cpu_op_t             cpu_op,
    input  logic [`ADDR_W-1:0]  cpu_addr,
    input  logic [`WORD_W-1:0]  cpu_wdata,
    output logic                resp_valid,
    output logic [`WORD_W-1:0]  resp_rdata,
    output logic                resp_hit,

    // Coherence unit refill
    output logic                fill_req_valid,
    input  logic                fill_req_ready,
    output logic [`ADDR_W-1:0]  fill_addr,
    input  logic                fill_valid,
    input  logic [`LINE_W-1:0]  fill_line,
    input  mesi_t               fill_state,

    // Snoop
    input  logic                snoop_valid,
    output logic                snoop_ready,
    input  logic [`ADDR_W-1:0]  snoop_addr,
    input  mesi_t               snoop_new_state,
    output logic                snoop_resp_valid,
    output logic                snoop_hit,
    output logic [`WORD_W-1:0]  snoop_data,
    output mesi_t               snoop_state
);

    store_if sif ();

    cache_ctrl ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .sif              (sif.ctrl),
        .cpu_valid        (cpu_valid),
        .cpu_ready        (cpu_ready),
        .cpu_op           (cpu_op),
        .cpu_addr         (cpu_addr),
        .cpu_wdata        (cpu_wdata),
        .resp_valid       (resp_valid),
        .resp_rdata       (resp_rdata),
        .resp_hit         (resp_hit),
        .fill_req_valid   (fill_req_valid),
        .fill_req_ready   (fill_req_ready),
        .fill_addr        (fill_addr),
        .fill_valid       (fill_valid),
        .fill_line        (fill_line),
        .fill_state       (fill_state),
        .snoop_valid      (snoop_valid),
        .snoop_ready      (snoop_ready),
        .snoop_addr       (snoop_addr),
        .snoop_new_state  (snoop_new_state),
        .snoop_resp_valid (snoop_resp_valid),
        .snoop_hit        (snoop_hit),
        .snoop_data       (snoop_data),
        .snoop_state      (snoop_state)
    );

    cache_store store_i (
        .clk (clk),
        .rst (rst),
        .sif (sif.store)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the L1 cache testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_l1_cache -o tb_l1_cache

./obj_dir/tb_l1_cache | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: sources.f
+incdir+.
cache_pkg.sv
bus_pkg.sv
store_if.sv
cache_store.sv
cache_ctrl.sv
l1_cache_top.sv
tb_clock.sv
tb_l1_cache.sv

// File: store_if.sv
// Interface between the cache controller and the tag, line and state storage
`timescale 1ns/1ps
`include "cache_config.svh"

interface store_if import cache_pkg::*; ();

    // Lookup path with read data combinational from rd_index
    logic [`INDEX_W-1:0] rd_index;
    logic [`TAG_W-1:0]   rd_tag;
    mesi_t               rd_state;
    line_u               rd_line;

    // Full line write
    logic                line_we;
    logic [`INDEX_W-1:0] wr_index;
    logic [`TAG_W-1:0]   wr_tag;
    line_u               wr_line;
    mesi_t               wr_state;

    // State-only write that loses to line_we on the same index
    logic                state_we;
    logic [`INDEX_W-1:0] st_index;
    mesi_t               st_state;

    modport ctrl (
        output rd_index, line_we, wr_index, wr_tag, wr_line, wr_state,
        output state_we, st_index, st_state,
        input  rd_tag, rd_state, rd_line
    );

    modport store (
        input  rd_index, line_we, wr_index, wr_tag, wr_line, wr_state,
        input  state_we, st_index, st_state,
        output rd_tag, rd_state, rd_line
    );

endinterface

// File: tb_clock.sv
// Clock and reset source for the L1 cache testbench, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // Released just after the edge
    end

endmodule

// File: tb_l1_cache.sv
// Testbench top for the L1 cache with refill memory model, random stimulus and assertion checks
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_l1_cache import cache_pkg::*, bus_pkg::*; ();

    // Two flushes of 256 cycles plus about 60 operations of up to 12 cycles each
    localparam int MAX_CYCLES = 3000;

    logic                clk;
    logic                rst;
    logic                cpu_valid;
    logic                cpu_ready;
    cpu_op_t             cpu_op;
    logic [`ADDR_W-1:0]  cpu_addr;
    logic [`WORD_W-1:0]  cpu_wdata;
    logic                resp_valid;
    logic [`WORD_W-1:0]  resp_rdata;
    logic                resp_hit;
    logic                fill_req_valid;
    logic                fill_req_ready;
    logic [`ADDR_W-1:0]  fill_addr;
    logic                fill_valid;
    logic [`LINE_W-1:0]  fill_line;
    mesi_t               fill_state;
    logic                snoop_valid;
    logic                snoop_ready;
    logic [`ADDR_W-1:0]  snoop_addr;
    mesi_t               snoop_new_state;
    logic                snoop_resp_valid;
    logic                snoop_hit;
    logic [`WORD_W-1:0]  snoop_data;
    mesi_t               snoop_state;

    logic [`WORD_W-1:0]  ref_mem [logic [`ADDR_W-1:0]];  // Coherent memory image by word address
    logic [`TAG_W-1:0]   ref_tag [`LINES];
    mesi_t               ref_st  [`LINES];

    logic                exp_hit = 1'b0;
    logic                exp_check = 1'b0;   // Response carries data to compare
    logic                exp_flush = 1'b0;
    logic [`WORD_W-1:0]  exp_rdata = '0;
    logic [`ADDR_W-1:0]  exp_fill_addr = '0;
    logic                exp_shit = 1'b0;
    logic [`WORD_W-1:0]  exp_sdata = '0;
    mesi_t               exp_sstate = I;

    int err_cnt = 0;
    int op_cnt = 0;
    int cycle_cnt = 0;
    int since_acc = 0;  // Cycles since the last processor acceptance

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    l1_cache_top l1_cache_top_i (.*);

    function automatic logic [`WORD_W-1:0] mem_word(input logic [`ADDR_W-1:0] addr);
        logic [`ADDR_W-1:0] key;
        key = {addr[`ADDR_W-1:2], 2'b00};
        if (ref_mem.exists(key)) begin
            return ref_mem[key];
        end
        return {key[15:0], key[31:16]} ^ 32'h9e37_79b9;  // Untouched words follow the address
    endfunction

    function automatic logic predict_hit(input logic [`ADDR_W-1:0] addr);
        return (ref_st[addr[11:4]] != I) && (ref_tag[addr[11:4]] == addr[31:12]);
    endfunction

    task automatic log_error(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    always @(posedge clk) begin
        if (cpu_valid && cpu_ready) begin
            since_acc <= 1;
        end else begin
            since_acc <= since_acc + 1;
        end
    end

    // Outputs are sampled on the falling edge between input changes
    reset_check: assert property (@(negedge clk) $fell(rst) |-> cpu_ready && snoop_ready &&
                                  !fill_req_valid && !resp_valid && !snoop_resp_valid)
        else log_error("handshake outputs are not idle after reset");
    resp_hit_check: assert property (@(negedge clk) disable iff (rst)
                                     resp_valid |-> resp_hit == exp_hit)
        else log_error($sformatf("error resp_hit: got %h expected %h", resp_hit, exp_hit));
    resp_data_check: assert property (@(negedge clk) disable iff (rst)
                                      resp_valid && exp_check |-> resp_rdata == exp_rdata)
        else log_error($sformatf("error resp_rdata: got %h expected %h", resp_rdata, exp_rdata));
    hit_latency_check: assert property (@(negedge clk) disable iff (rst)
                                        resp_valid && resp_hit |-> since_acc == 1)
        else log_error($sformatf("hit response came %0d cycles after acceptance", since_acc));
    flush_latency_check: assert property (@(negedge clk) disable iff (rst)
                                          resp_valid && exp_flush |-> since_acc == 256)
        else log_error($sformatf("flush finished %0d cycles after acceptance", since_acc));
    fill_addr_check: assert property (@(negedge clk) disable iff (rst)
                                      fill_req_valid |-> fill_addr == exp_fill_addr)
        else log_error($sformatf("error fill_addr: got %h expected %h", fill_addr, exp_fill_addr));
    fill_hold_check: assert property (@(negedge clk) disable iff (rst)
                                      $past(fill_req_valid && !fill_req_ready) |->
                                      fill_req_valid && $stable(fill_addr))
        else log_error("refill request dropped or moved while fill_req_ready was low");
    stall_ready_check: assert property (@(negedge clk) disable iff (rst)
                                        fill_req_valid |-> !cpu_ready)
        else log_error("cpu_ready high while a refill request is pending");
    snoop_prio_check: assert property (@(negedge clk) disable iff (rst)
                                       snoop_valid |-> !cpu_ready)
        else log_error("cpu_ready high while snoop_valid is high");
    snoop_latency_check: assert property (@(negedge clk) disable iff (rst)
                                          snoop_resp_valid |-> $past(snoop_valid && snoop_ready))
        else log_error("snoop response not in the first cycle after acceptance");
    snoop_hit_check: assert property (@(negedge clk) disable iff (rst)
                                      snoop_resp_valid |-> snoop_hit == exp_shit)
        else log_error($sformatf("error snoop_hit: got %h expected %h", snoop_hit, exp_shit));
    snoop_data_check: assert property (@(negedge clk) disable iff (rst)
                                       snoop_resp_valid && exp_shit |-> snoop_data == exp_sdata)
        else log_error($sformatf("error snoop_data: got %h expected %h", snoop_data, exp_sdata));
    snoop_state_check: assert property (@(negedge clk) disable iff (rst)
                                        snoop_resp_valid && exp_shit |-> snoop_state == exp_sstate)
        else log_error($sformatf("error snoop_state: got %h expected %h", snoop_state, exp_sstate));

    // Coherence unit model that answers each refill from the reference memory
    initial begin : refill_model
        logic [`ADDR_W-1:0] line_a;
        int unsigned        stall_cyc;
        stall_cyc      = 0;
        fill_req_ready = 1'b1;
        fill_valid     = 1'b0;
        fill_line      = '0;
        fill_state     = E;
        forever begin
            @(negedge clk);
            if (fill_req_valid) begin
                line_a = fill_addr;
                if (stall_cyc > 0) begin
                    repeat (stall_cyc) @(posedge clk);
                    #1 fill_req_ready = 1'b1;
                end
                @(posedge clk);  // Accepting edge
                stall_cyc = $urandom_range(3, 0);
                #1 fill_req_ready = (stall_cyc == 0);
                @(posedge clk);
                @(posedge clk);
                #1;
                for (int w = 0; w < `WORDS_PER_LINE; w++) begin
                    fill_line[w*`WORD_W +: `WORD_W] = mem_word({line_a[31:4], w[1:0], 2'b00});
                end
                fill_valid = 1'b1;
                @(posedge clk);
                #1 fill_valid = 1'b0;
            end
        end
    end

    task automatic cpu_request(input cpu_op_t op, input logic [`ADDR_W-1:0] addr,
                               input logic [`WORD_W-1:0] wdata);
        logic [`INDEX_W-1:0] idx;
        int                  i;
        idx           = addr[11:4];
        exp_check     = (op != OP_FLUSH);
        exp_flush     = (op == OP_FLUSH);
        exp_hit       = exp_check && predict_hit(addr);
        exp_rdata     = (op == OP_WRITE) ? wdata : mem_word(addr);
        exp_fill_addr = {addr[31:4], 4'h0};
        cpu_op        = op;
        cpu_addr      = addr;
        cpu_wdata     = wdata;
        cpu_valid     = 1'b1;
        @(negedge clk);
        while (!cpu_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1 cpu_valid = 1'b0;
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
        end
        if (op == OP_FLUSH) begin
            for (i = 0; i < `LINES; i++) begin
                ref_st[i] = I;
            end
        end else begin
            if (!exp_hit) begin
                ref_tag[idx] = addr[31:12];  // Refilled line arrives in E
                ref_st[idx]  = E;
            end
            if (op == OP_WRITE) begin
                ref_st[idx] = M;
                ref_mem[{addr[31:2], 2'b00}] = wdata;
            end
        end
        op_cnt++;
        @(posedge clk);
        #1;
    endtask

    task automatic snoop_request(input logic [`ADDR_W-1:0] addr, input mesi_t new_st);
        exp_shit        = predict_hit(addr);
        exp_sdata       = mem_word(addr);
        exp_sstate      = ref_st[addr[11:4]];
        snoop_addr      = addr;
        snoop_new_state = new_st;
        snoop_valid     = 1'b1;
        @(negedge clk);
        while (!snoop_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1 snoop_valid = 1'b0;
        @(negedge clk);
        while (!snoop_resp_valid) begin
            @(negedge clk);
        end
        if (exp_shit) begin
            ref_st[addr[11:4]] = new_st;
        end
        op_cnt++;
        @(posedge clk);
        #1;
    endtask

    initial begin : stimulus
        logic [`ADDR_W-1:0] a;
        logic [`ADDR_W-1:0] seen [$];  // Addresses touched before the first flush
        int                 k;
        int                 w;
        void'($urandom(41320));
        cpu_valid       = 1'b0;
        cpu_op          = OP_READ;
        cpu_addr        = '0;
        cpu_wdata       = '0;
        snoop_valid     = 1'b0;
        snoop_addr      = '0;
        snoop_new_state = I;
        for (k = 0; k < `LINES; k++) begin
            ref_st[k] = I;
        end
        @(negedge rst);
        @(posedge clk);
        #1;
        for (k = 0; k < 5; k++) begin
            a = $urandom;
            seen.push_back(a);
            cpu_request(OP_READ, a, '0);  // Miss then hit
            cpu_request(OP_READ, a, '0);
            cpu_request(OP_WRITE, a ^ ($urandom & 32'hc), $urandom);
            for (w = 0; w < `WORDS_PER_LINE; w++) begin
                cpu_request(OP_READ, {a[31:4], w[1:0], a[1:0]}, '0);
            end
        end
        for (k = 0; k < 4; k++) begin
            a = $urandom;
            seen.push_back(a);
            cpu_request(OP_WRITE, a, $urandom);  // Write miss merges into the refill
            cpu_request(OP_READ, a ^ 32'h4, '0);
        end
        snoop_request(a, S);
        snoop_request({~a[31:12], a[11:0]}, I);  // Other tag on a valid line
        snoop_request(a, I);
        snoop_request(a, S);  // Line already invalid
        cpu_request(OP_FLUSH, '0, '0);
        foreach (seen[j]) begin
            snoop_request(seen[j], I);
            cpu_request(OP_READ, seen[j], '0);
        end
        cpu_request(OP_FLUSH, '0, '0);
        repeat (2) @(posedge clk);
        $display("checks finished: %0d operations, %0d errors", op_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles before the tests completed", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

endmodule
